// File: design/sd_host_pkg.sv
package sd_host_pkg;

    // Wishbone bus
    localparam int WB_ADDR_W = 3;
    localparam int WB_DATA_W = 32;

    // Register map in word addresses
    localparam logic [WB_ADDR_W-1:0] REG_ARGUMENT   = 3'd0;
    localparam logic [WB_ADDR_W-1:0] REG_COMMAND    = 3'd1;
    localparam logic [WB_ADDR_W-1:0] REG_RESPONSE   = 3'd2;
    localparam logic [WB_ADDR_W-1:0] REG_INT_STATUS = 3'd3;
    localparam logic [WB_ADDR_W-1:0] REG_INT_ENABLE = 3'd4;
    localparam logic [WB_ADDR_W-1:0] REG_CLK_DIV    = 3'd5;
    localparam logic [WB_ADDR_W-1:0] REG_PRESENT    = 3'd6;
    localparam logic [WB_ADDR_W-1:0] REG_SOFT_RESET = 3'd7;

    // Command frame
    localparam int CMD_INDEX_W  = 6;
    localparam int CRC7_W       = 7;
    localparam int CMD_FRAME_W  = 48;
    localparam int CMD_BODY_W   = CMD_FRAME_W - CRC7_W - 1;
    localparam int BIT_CNT_W    = $clog2(CMD_FRAME_W + 1);
    localparam int RESP_TIMEOUT = 64;
    localparam int TO_CNT_W     = $clog2(RESP_TIMEOUT);

    // Card clock
    localparam int                   CLK_DIV_W     = 8;
    localparam logic [CLK_DIV_W-1:0] CLK_DIV_RESET = 8'd1;

    // Interrupt status bits
    localparam int INT_W             = 4;
    localparam int INT_CMD_DONE      = 0;
    localparam int INT_CMD_TIMEOUT   = 1;
    localparam int INT_CMD_CRC_ERR   = 2;
    localparam int INT_CMD_INDEX_ERR = 3;

    typedef enum logic [1:0] {
        RESP_NONE  = 2'd0,
        RESP_SHORT = 2'd1
    } resp_type_e;

    typedef enum logic [1:0] {
        IDLE = 2'd0,
        SEND = 2'd1,
        WAIT = 2'd2
    } cmd_state_e;

    typedef struct packed {
        logic                 cyc;
        logic                 stb;
        logic                 we;
        logic [WB_ADDR_W-1:0] adr;
        logic [WB_DATA_W-1:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic                 ack;
        logic [WB_DATA_W-1:0] dat;
    } wb_rsp_t;

    typedef struct packed {
        logic [CMD_INDEX_W-1:0] index;
        logic [31:0]            arg;
        resp_type_e             resp;
    } cmd_req_t;

    typedef struct packed {
        logic        timeout;
        logic        crc_ok;
        logic        index_ok;
        logic [31:0] arg;
    } cmd_result_t;

endpackage

// File: design/sd_clock_divider.sv
`timescale 1ns/1ps

module sd_clock_divider import sd_host_pkg::*; (
    input  logic                 wb_clk_i,
    input  logic                 rst_n_i,
    input  logic [CLK_DIV_W-1:0] clk_div_i,
    output logic                 sd_clk_o,
    output logic                 sd_rise_o,
    output logic                 sd_fall_o
);

    logic [CLK_DIV_W-1:0] cnt;
    logic [CLK_DIV_W-1:0] div_q;
    logic                 sd_clk_q;
    logic                 tick;

    // Half period of div + 1 bus cycles
    assign tick = (clk_div_i == div_q) && (cnt == div_q);

    always_ff @(posedge wb_clk_i) begin
        if (!rst_n_i) begin
            cnt      <= '0;
            div_q    <= CLK_DIV_RESET;
            sd_clk_q <= 1'b0;
        end else if (clk_div_i != div_q) begin
            div_q <= clk_div_i;
            cnt   <= '0;
        end else if (tick) begin
            cnt      <= '0;
            sd_clk_q <= ~sd_clk_q;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // Strobes coincide with the bus edge that moves the card clock
    assign sd_rise_o = tick && !sd_clk_q;
    assign sd_fall_o = tick && sd_clk_q;
    assign sd_clk_o  = sd_clk_q;

endmodule

// File: design/sd_cmd_serial.sv
`timescale 1ns/1ps

module sd_cmd_serial import sd_host_pkg::*; (
    input  logic        wb_clk_i,
    input  logic        rst_n_i,
    input  logic        ser_rst_i,
    input  logic        sd_rise_i,
    input  logic        sd_fall_i,
    input  logic        start_i,
    input  cmd_req_t    req_i,
    output logic        finish_o,
    output cmd_result_t result_o,
    output logic        sd_cmd_o,
    output logic        sd_cmd_oe_o,
    input  logic        sd_cmd_i
);

    logic                   tx_on;
    logic                   rx_wait;
    logic                   rx_on;
    logic                   cmd_q;
    logic                   oe_q;
    logic                   finish_q;
    logic [CMD_BODY_W-1:0]  sr;
    logic [CRC7_W-1:0]      crc;
    logic                   crc_err;
    logic [BIT_CNT_W-1:0]   bit_cnt;
    logic [TO_CNT_W-1:0]    to_cnt;
    logic [CMD_INDEX_W-1:0] idx_q;
    resp_type_e             resp_q;
    cmd_result_t            result_q;

    // CRC7 step for x^7 + x^3 + 1
    function automatic logic [CRC7_W-1:0] crc7_next(input logic [CRC7_W-1:0] c,
                                                     input logic b);
        logic fb;
        fb = c[CRC7_W-1] ^ b;
        crc7_next = {c[CRC7_W-2:0], 1'b0} ^ {3'b000, fb, 2'b00, fb};
    endfunction

    always_ff @(posedge wb_clk_i) begin
        finish_q <= 1'b0;
        if (!rst_n_i || ser_rst_i) begin
            tx_on   <= 1'b0;
            rx_wait <= 1'b0;
            rx_on   <= 1'b0;
            cmd_q   <= 1'b1;
            oe_q    <= 1'b0;
        end else if (start_i) begin
            tx_on   <= 1'b1;
            sr      <= {1'b0, 1'b1, req_i.index, req_i.arg};
            crc     <= '0;
            bit_cnt <= '0;
            idx_q   <= req_i.index;
            resp_q  <= req_i.resp;
        end else if (tx_on && sd_fall_i) begin
            if (bit_cnt == BIT_CNT_W'(CMD_FRAME_W)) begin
                // Line released after the end bit
                tx_on   <= 1'b0;
                oe_q    <= 1'b0;
                cmd_q   <= 1'b1;
                bit_cnt <= '0;
                crc     <= '0;
                crc_err <= 1'b0;
                to_cnt  <= '0;
                if (resp_q == RESP_SHORT) begin
                    rx_wait <= 1'b1;
                end else begin
                    finish_q <= 1'b1;
                    result_q <= '{timeout: 1'b0, crc_ok: 1'b1, index_ok: 1'b1, arg: '0};
                end
            end else begin
                oe_q    <= 1'b1;
                bit_cnt <= bit_cnt + 1'b1;
                if (bit_cnt < BIT_CNT_W'(CMD_BODY_W)) begin
                    cmd_q <= sr[CMD_BODY_W-1];
                    sr    <= {sr[CMD_BODY_W-2:0], 1'b0};
                    crc   <= crc7_next(crc, sr[CMD_BODY_W-1]);
                end else if (bit_cnt < BIT_CNT_W'(CMD_FRAME_W - 1)) begin
                    cmd_q <= crc[CRC7_W-1];
                    crc   <= {crc[CRC7_W-2:0], 1'b0};
                end else begin
                    cmd_q <= 1'b1;
                end
            end
        end else if (rx_wait && sd_rise_i) begin
            if (!sd_cmd_i) begin
                // CRC of the leading zero start bit stays zero
                rx_wait <= 1'b0;
                rx_on   <= 1'b1;
                bit_cnt <= BIT_CNT_W'(1);
                sr      <= {sr[CMD_BODY_W-2:0], sd_cmd_i};
            end else if (to_cnt == TO_CNT_W'(RESP_TIMEOUT - 1)) begin
                rx_wait  <= 1'b0;
                finish_q <= 1'b1;
                result_q <= '{timeout: 1'b1, crc_ok: 1'b0, index_ok: 1'b0, arg: '0};
            end else begin
                to_cnt <= to_cnt + 1'b1;
            end
        end else if (rx_on && sd_rise_i) begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt < BIT_CNT_W'(CMD_BODY_W)) begin
                sr  <= {sr[CMD_BODY_W-2:0], sd_cmd_i};
                crc <= crc7_next(crc, sd_cmd_i);
            end else if (bit_cnt < BIT_CNT_W'(CMD_FRAME_W - 1)) begin
                if (sd_cmd_i != crc[CRC7_W-1])
                    crc_err <= 1'b1;
                crc <= {crc[CRC7_W-2:0], 1'b0};
            end else begin
                // End bit
                rx_on    <= 1'b0;
                finish_q <= 1'b1;
                result_q <= '{timeout:  1'b0,
                              crc_ok:   !crc_err,
                              index_ok: sr[CMD_BODY_W-3 -: CMD_INDEX_W] == idx_q,
                              arg:      sr[31:0]};
            end
        end
    end

    assign finish_o    = finish_q;
    assign result_o    = result_q;
    assign sd_cmd_o    = cmd_q;
    assign sd_cmd_oe_o = oe_q;

endmodule

// File: design/sd_cmd_master.sv
`timescale 1ns/1ps

module sd_cmd_master import sd_host_pkg::*; (
    input  logic             wb_clk_i,
    input  logic             rst_n_i,
    input  logic             cmd_start_i,
    input  cmd_req_t         cmd_req_i,
    input  logic             soft_rst_i,
    output logic             busy_o,
    output logic [INT_W-1:0] events_o,
    output logic [31:0]      resp_arg_o,
    output logic             xfr_start_o,
    output cmd_req_t         xfr_req_o,
    output logic             ser_rst_o,
    input  logic             finish_i,
    input  cmd_result_t      result_i
);

    cmd_state_e       state;
    cmd_req_t         req_q;
    logic             ser_rst_q;
    logic [INT_W-1:0] ev;

    always_ff @(posedge wb_clk_i) begin
        if (!rst_n_i) begin
            state     <= IDLE;
            ser_rst_q <= 1'b0;
        end else begin
            ser_rst_q <= soft_rst_i;
            if (soft_rst_i) begin
                state <= IDLE;
            end else begin
                case (state)
                    IDLE: if (cmd_start_i) state <= SEND;
                    SEND: state <= WAIT;
                    WAIT: if (finish_i) state <= IDLE;
                    default: state <= IDLE;
                endcase
            end
        end
    end

    // Starts while busy are dropped here
    always_ff @(posedge wb_clk_i) begin
        if (state == IDLE && cmd_start_i)
            req_q <= cmd_req_i;
    end

    always_comb begin
        ev = '0;
        ev[INT_CMD_DONE] = 1'b1;
        if (req_q.resp == RESP_SHORT) begin
            if (result_i.timeout) begin
                ev[INT_CMD_TIMEOUT] = 1'b1;
            end else begin
                ev[INT_CMD_CRC_ERR]   = !result_i.crc_ok;
                ev[INT_CMD_INDEX_ERR] = !result_i.index_ok;
            end
        end
    end

    // Aborted commands report nothing
    assign events_o    = (state == WAIT && finish_i && !soft_rst_i) ? ev : '0;
    assign resp_arg_o  = result_i.arg;
    assign busy_o      = (state != IDLE);
    assign xfr_start_o = (state == SEND);
    assign xfr_req_o   = req_q;
    assign ser_rst_o   = ser_rst_q;

endmodule

// File: design/sd_host_regs.sv
`timescale 1ns/1ps

module sd_host_regs import sd_host_pkg::*; (
    input  logic                 wb_clk_i,
    input  logic                 rst_n_i,
    input  wb_req_t              wb_req_i,
    output wb_rsp_t              wb_rsp_o,
    output logic                 cmd_start_o,
    output cmd_req_t             cmd_req_o,
    output logic                 soft_rst_o,
    input  logic                 busy_i,
    input  logic [INT_W-1:0]     events_i,
    input  logic [31:0]          resp_arg_i,
    output logic [CLK_DIV_W-1:0] clk_div_o,
    output logic                 int_o
);

    logic                   ack_q;
    logic [WB_DATA_W-1:0]   rdata_q;
    logic [WB_DATA_W-1:0]   rdata_d;
    logic [31:0]            argument_q;
    logic [CMD_INDEX_W+1:0] command_q;
    logic [31:0]            response_q;
    logic [INT_W-1:0]       int_status_q;
    logic [INT_W-1:0]       int_enable_q;
    logic [CLK_DIV_W-1:0]   clk_div_q;
    logic                   cmd_start_q;
    logic                   soft_rst_q;
    logic                   access;
    logic                   wr_en;
    logic [INT_W-1:0]       int_clr;

    // Ack follows one cycle after an accepted request
    assign access = wb_req_i.cyc && wb_req_i.stb && !ack_q;
    assign wr_en  = access && wb_req_i.we;

    assign int_clr = (wr_en && wb_req_i.adr == REG_INT_STATUS) ?
                     wb_req_i.dat[INT_W-1:0] : '0;

    always_ff @(posedge wb_clk_i) begin
        if (!rst_n_i) begin
            ack_q        <= 1'b0;
            command_q    <= '0;
            int_status_q <= '0;
            int_enable_q <= '0;
            clk_div_q    <= CLK_DIV_RESET;
            cmd_start_q  <= 1'b0;
            soft_rst_q   <= 1'b0;
        end else begin
            ack_q       <= access;
            cmd_start_q <= wr_en && wb_req_i.adr == REG_COMMAND;
            soft_rst_q  <= wr_en && wb_req_i.adr == REG_SOFT_RESET && wb_req_i.dat[0];
            // New events take priority over a clear
            int_status_q <= (int_status_q & ~int_clr) | events_i;
            if (wr_en && wb_req_i.adr == REG_COMMAND)
                command_q <= wb_req_i.dat[CMD_INDEX_W+1:0];
            if (wr_en && wb_req_i.adr == REG_INT_ENABLE)
                int_enable_q <= wb_req_i.dat[INT_W-1:0];
            if (wr_en && wb_req_i.adr == REG_CLK_DIV)
                clk_div_q <= wb_req_i.dat[CLK_DIV_W-1:0];
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (access)
            rdata_q <= rdata_d;
        if (wr_en && wb_req_i.adr == REG_ARGUMENT)
            argument_q <= wb_req_i.dat;
        if (events_i[INT_CMD_DONE])
            response_q <= resp_arg_i;
    end

    always_comb begin
        rdata_d = '0;
        case (wb_req_i.adr)
            REG_ARGUMENT:   rdata_d = argument_q;
            REG_COMMAND:    rdata_d[CMD_INDEX_W+1:0] = command_q;
            REG_RESPONSE:   rdata_d = response_q;
            REG_INT_STATUS: rdata_d[INT_W-1:0] = int_status_q;
            REG_INT_ENABLE: rdata_d[INT_W-1:0] = int_enable_q;
            REG_CLK_DIV:    rdata_d[CLK_DIV_W-1:0] = clk_div_q;
            REG_PRESENT:    rdata_d[0] = busy_i;
            default:        rdata_d = '0;
        endcase
    end

    always_comb begin
        cmd_req_o.index = command_q[CMD_INDEX_W-1:0];
        cmd_req_o.arg   = argument_q;
        cmd_req_o.resp  = resp_type_e'(command_q[CMD_INDEX_W+1:CMD_INDEX_W]);
    end

    assign wb_rsp_o.ack = ack_q;
    assign wb_rsp_o.dat = rdata_q;
    assign cmd_start_o  = cmd_start_q;
    assign soft_rst_o   = soft_rst_q;
    assign clk_div_o    = clk_div_q;
    assign int_o        = |(int_status_q & int_enable_q);

endmodule

// File: design/sd_host_top.sv
`timescale 1ns/1ps

module sd_host_top import sd_host_pkg::*; (
    input  logic    wb_clk_i,
    input  logic    rst_n_i,
    input  wb_req_t wb_req_i,
    output wb_rsp_t wb_rsp_o,
    output logic    sd_clk_o,
    output logic    sd_cmd_o,
    output logic    sd_cmd_oe_o,
    input  logic    sd_cmd_i,
    output logic    int_o
);

    logic                 cmd_start;
    cmd_req_t             cmd_req;
    logic                 soft_rst;
    logic                 busy;
    logic [INT_W-1:0]     events;
    logic [31:0]          resp_arg;
    logic [CLK_DIV_W-1:0] clk_div;
    logic                 sd_rise;
    logic                 sd_fall;
    logic                 xfr_start;
    cmd_req_t             xfr_req;
    logic                 ser_rst;
    logic                 finish;
    cmd_result_t          result;

    sd_host_regs sd_host_regs_i (
        .wb_clk_i    (wb_clk_i),
        .rst_n_i     (rst_n_i),
        .wb_req_i    (wb_req_i),
        .wb_rsp_o    (wb_rsp_o),
        .cmd_start_o (cmd_start),
        .cmd_req_o   (cmd_req),
        .soft_rst_o  (soft_rst),
        .busy_i      (busy),
        .events_i    (events),
        .resp_arg_i  (resp_arg),
        .clk_div_o   (clk_div),
        .int_o       (int_o)
    );

    sd_clock_divider sd_clock_divider_i (
        .wb_clk_i  (wb_clk_i),
        .rst_n_i   (rst_n_i),
        .clk_div_i (clk_div),
        .sd_clk_o  (sd_clk_o),
        .sd_rise_o (sd_rise),
        .sd_fall_o (sd_fall)
    );

    sd_cmd_master sd_cmd_master_i (
        .wb_clk_i    (wb_clk_i),
        .rst_n_i     (rst_n_i),
        .cmd_start_i (cmd_start),
        .cmd_req_i   (cmd_req),
        .soft_rst_i  (soft_rst),
        .busy_o      (busy),
        .events_o    (events),
        .resp_arg_o  (resp_arg),
        .xfr_start_o (xfr_start),
        .xfr_req_o   (xfr_req),
        .ser_rst_o   (ser_rst),
        .finish_i    (finish),
        .result_i    (result)
    );

    sd_cmd_serial sd_cmd_serial_i (
        .wb_clk_i    (wb_clk_i),
        .rst_n_i     (rst_n_i),
        .ser_rst_i   (ser_rst),
        .sd_rise_i   (sd_rise),
        .sd_fall_i   (sd_fall),
        .start_i     (xfr_start),
        .req_i       (xfr_req),
        .finish_o    (finish),
        .result_o    (result),
        .sd_cmd_o    (sd_cmd_o),
        .sd_cmd_oe_o (sd_cmd_oe_o),
        .sd_cmd_i    (sd_cmd_i)
    );

endmodule

// File: tb/sd_host_checker.sv
`timescale 1ns/1ps

module sd_host_checker import sd_host_pkg::*; (
    input logic             wb_clk_i,
    input logic             rst_n_i,
    input wb_req_t          wb_req_i,
    input wb_rsp_t          wb_rsp_i,
    input logic             cmd_line_i,
    input logic             cmd_oe_i,
    input logic             int_i,
    input logic [INT_W-1:0] int_enable_i
);

    ack_with_request: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
        wb_rsp_i.ack |-> (wb_req_i.cyc && wb_req_i.stb))
        else $error("Wishbone ack without an active request");

    ack_single_cycle: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
        wb_rsp_i.ack |=> !wb_rsp_i.ack)
        else $error("Wishbone ack held for two cycles");

    // Released CMD line idles high
    cmd_idle_high: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
        !cmd_oe_i |-> cmd_line_i)
        else $error("CMD line low while not driven");

    // int_o agrees with the status value that a bus read returns
    int_masked: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
        (wb_rsp_i.ack && !wb_req_i.we && wb_req_i.adr == REG_INT_STATUS) |->
        ($past(int_i) == |(wb_rsp_i.dat[INT_W-1:0] & $past(int_enable_i))))
        else $error("int_o differs from masked interrupt status");

endmodule

bind sd_host_top sd_host_checker sd_host_checker_i (
    .wb_clk_i     (wb_clk_i),
    .rst_n_i      (rst_n_i),
    .wb_req_i     (wb_req_i),
    .wb_rsp_i     (wb_rsp_o),
    .cmd_line_i   (sd_cmd_o),
    .cmd_oe_i     (sd_cmd_oe_o),
    .int_i        (int_o),
    .int_enable_i (sd_host_regs_i.int_enable_q)
);

// File: tb/sd_host_tb.sv
`timescale 1ns/1ps

module sd_host_tb import sd_host_pkg::*; ();

    logic    wb_clk;
    logic    rst_n;
    wb_req_t wb_req;
    wb_rsp_t wb_rsp;
    logic    sd_clk;
    logic    sd_cmd;
    logic    sd_cmd_oe;
    logic    sd_cmd_in;
    logic    int_line;

    logic [31:0] lfsr = 32'h169e;
    int          err_cnt;
    int          chk_cnt;
    int          test_cnt;

    sd_host_top sd_host_top_i (
        .wb_clk_i    (wb_clk),
        .rst_n_i     (rst_n),
        .wb_req_i    (wb_req),
        .wb_rsp_o    (wb_rsp),
        .sd_clk_o    (sd_clk),
        .sd_cmd_o    (sd_cmd),
        .sd_cmd_oe_o (sd_cmd_oe),
        .sd_cmd_i    (sd_cmd_in),
        .int_o       (int_line)
    );

    always #50 wb_clk = ~wb_clk;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hD000_0001) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
        return v;
    endfunction

    // CRC7 with generator x^7 + x^3 + 1 taken MSB first
    function automatic logic [6:0] crc7(input logic [39:0] body);
        logic [6:0] c;
        logic       msb;
        c = '0;
        for (int i = 39; i >= 0; i--) begin
            msb = c[6] ^ body[i];
            c   = c << 1;
            if (msb)
                c = c ^ 7'h09;
        end
        return c;
    endfunction

    task automatic check(input string name, input logic [47:0] got, input logic [47:0] exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("[FAIL] t=%0t %s: got %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic report_test(input string name, input int start);
        test_cnt++;
        if (err_cnt == start)
            $display("test %0d, %s: ok", test_cnt, name);
        else
            $display("test %0d, %s: %0d error(s)", test_cnt, name, err_cnt - start);
    endtask

    task automatic wb_access(input logic we, input logic [WB_ADDR_W-1:0] adr,
                             input logic [31:0] wdat, output logic [31:0] rdat);
        int n;
        n = 0;
        @(posedge wb_clk);
        wb_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
        do begin
            @(posedge wb_clk);
            n++;
        end while (!wb_rsp.ack && n < 8);
        rdat = wb_rsp.dat;
        wb_req <= '0;
        if (!wb_rsp.ack) begin
            err_cnt++;
            $display("t=%0t: no Wishbone ack for address %0d", $time, adr);
        end
    endtask

    task automatic wb_write(input logic [WB_ADDR_W-1:0] adr, input logic [31:0] dat);
        logic [31:0] ignored;
        wb_access(1'b1, adr, dat, ignored);
    endtask

    task automatic wb_read(input logic [WB_ADDR_W-1:0] adr, output logic [31:0] dat);
        wb_access(1'b0, adr, 32'h0, dat);
    endtask

    // Returns when sd_clk_o moves to the given level
    task automatic sd_clk_edge(input logic level);
        int   n;
        logic prev;
        logic seen;
        prev = sd_clk;
        seen = 1'b0;
        for (n = 0; n < 2000 && !seen; n++) begin
            @(sd_clk or posedge wb_clk);
            seen = (sd_clk !== prev) && (sd_clk === level);
            prev = sd_clk;
        end
        if (!seen) begin
            err_cnt++;
            $display("t=%0t: sd_clk_o stopped toggling", $time);
        end
    endtask

    // Card side samples frame bits on rising card clock edges
    task automatic capture_frame(output logic [47:0] frame);
        int   n;
        logic found;
        frame = '0;
        found = 1'b0;
        for (n = 0; n < 200 && !found; n++) begin
            sd_clk_edge(1'b1);
            found = sd_cmd_oe;
        end
        if (!found) begin
            err_cnt++;
            $display("t=%0t: the CMD line was never driven", $time);
        end else begin
            frame[47] = sd_cmd;
            for (int i = 46; i >= 0; i--) begin
                sd_clk_edge(1'b1);
                frame[i] = sd_cmd;
            end
        end
    endtask

    task automatic send_response(input logic [47:0] frame);
        // Line turnaround plus one idle card clock
        repeat (2) sd_clk_edge(1'b0);
        for (int i = 47; i >= 0; i--) begin
            sd_clk_edge(1'b0);
            sd_cmd_in <= frame[i];
        end
    endtask

    task automatic wait_done(output logic [31:0] status);
        int n;
        status = '0;
        for (n = 0; n < 300 && !status[INT_CMD_DONE]; n++)
            wb_read(REG_INT_STATUS, status);
        if (!status[INT_CMD_DONE]) begin
            err_cnt++;
            $display("t=%0t: command never reported done in INT_STATUS", $time);
        end
    endtask

    task automatic issue_command(input logic [5:0] idx, input logic [31:0] arg,
                                 input resp_type_e resp);
        wb_write(REG_ARGUMENT, arg);
        wb_write(REG_COMMAND, {24'h0, resp, idx});
    endtask

    // Card answers with optional damage to the index or the CRC
    task automatic short_exchange(input logic [5:0] idx_flip, input logic [6:0] crc_flip,
                                  output logic [31:0] status, output logic [31:0] card_arg);
        logic [5:0]  idx;
        logic [5:0]  rsp_idx;
        logic [31:0] arg;
        logic [47:0] frame;
        idx      = 6'(rand_bits(6));
        arg      = rand_bits(32);
        card_arg = rand_bits(32);
        rsp_idx  = idx ^ idx_flip;
        issue_command(idx, arg, RESP_SHORT);
        capture_frame(frame);
        check("cmd index", 48'(frame[45:40]), 48'(idx));
        frame = {2'b00, rsp_idx, card_arg, crc7({2'b00, rsp_idx, card_arg}) ^ crc_flip, 1'b1};
        send_response(frame);
        wait_done(status);
    endtask

    task automatic test_reset();
        logic [31:0] rd;
        int          start;
        start = err_cnt;
        check("int_o", 48'(int_line), 48'(0));
        check("sd_cmd_oe_o", 48'(sd_cmd_oe), 48'(0));
        wb_read(REG_INT_STATUS, rd);
        check("INT_STATUS", 48'(rd), 48'(0));
        wb_read(REG_CLK_DIV, rd);
        check("CLK_DIV", 48'(rd), 48'(1));
        wb_read(REG_PRESENT, rd);
        check("PRESENT", 48'(rd), 48'(0));
        report_test("reset state", start);
    endtask

    task automatic test_no_response();
        logic [5:0]  idx;
        logic [31:0] arg;
        logic [47:0] frame;
        logic [31:0] present;
        logic [31:0] status;
        int          start;
        start = err_cnt;
        idx   = 6'(rand_bits(6));
        arg   = rand_bits(32);
        wb_write(REG_INT_ENABLE, 32'h1 << INT_CMD_DONE);
        issue_command(idx, arg, RESP_NONE);
        fork
            capture_frame(frame);
            wb_read(REG_PRESENT, present);
        join
        check("PRESENT inhibit", 48'(present[0]), 48'(1));
        check("cmd start bit", 48'(frame[47]), 48'(0));
        check("cmd transmission bit", 48'(frame[46]), 48'(1));
        check("cmd index", 48'(frame[45:40]), 48'(idx));
        check("cmd argument", 48'(frame[39:8]), 48'(arg));
        check("cmd crc7", 48'(frame[7:1]), 48'(crc7({2'b01, idx, arg})));
        check("cmd end bit", 48'(frame[0]), 48'(1));
        wait_done(status);
        check("INT_STATUS", 48'(status), 48'(1 << INT_CMD_DONE));
        check("int_o", 48'(int_line), 48'(1));
        check("sd_cmd_oe_o", 48'(sd_cmd_oe), 48'(0));
        wb_write(REG_INT_STATUS, 32'hF);
        report_test("command without response", start);
    endtask

    task automatic test_good_response();
        logic [31:0] status;
        logic [31:0] card_arg;
        logic [31:0] rd;
        int          start;
        start = err_cnt;
        short_exchange(6'h00, 7'h00, status, card_arg);
        check("INT_STATUS", 48'(status), 48'(1 << INT_CMD_DONE));
        wb_read(REG_RESPONSE, rd);
        check("RESPONSE", 48'(rd), 48'(card_arg));
        wb_write(REG_INT_STATUS, 32'hF);
        report_test("good short response", start);
    endtask

    task automatic test_bad_response();
        logic [31:0] status;
        logic [31:0] card_arg;
        int          start;
        start = err_cnt;
        short_exchange(6'h00, 7'h04, status, card_arg);
        check("INT_STATUS crc", 48'(status),
              48'((1 << INT_CMD_DONE) | (1 << INT_CMD_CRC_ERR)));
        wb_write(REG_INT_STATUS, 32'hF);
        short_exchange(6'h20, 7'h00, status, card_arg);
        check("INT_STATUS index", 48'(status),
              48'((1 << INT_CMD_DONE) | (1 << INT_CMD_INDEX_ERR)));
        wb_write(REG_INT_STATUS, 32'hF);
        report_test("corrupted response", start);
    endtask

    task automatic test_missing_response();
        logic [47:0] frame;
        logic [31:0] status;
        int          start;
        start = err_cnt;
        issue_command(6'(rand_bits(6)), rand_bits(32), RESP_SHORT);
        capture_frame(frame);
        wait_done(status);
        check("INT_STATUS", 48'(status),
              48'((1 << INT_CMD_DONE) | (1 << INT_CMD_TIMEOUT)));
        wb_write(REG_INT_STATUS, 32'hF);
        report_test("missing response", start);
    endtask

    task automatic test_irq_and_clock();
        logic [31:0] status;
        logic [7:0]  div;
        logic [31:0] rd;
        time         t0;
        time         t1;
        int          start;
        start = err_cnt;
        wb_write(REG_INT_ENABLE, 32'h0);
        issue_command(6'(rand_bits(6)), rand_bits(32), RESP_NONE);
        wait_done(status);
        check("INT_STATUS", 48'(status), 48'(1 << INT_CMD_DONE));
        check("int_o masked", 48'(int_line), 48'(0));
        wb_write(REG_INT_STATUS, 32'h1 << INT_CMD_DONE);
        wb_read(REG_INT_STATUS, rd);
        check("INT_STATUS cleared", 48'(rd), 48'(0));
        div = 8'(rand_bits(3));
        wb_write(REG_CLK_DIV, {24'h0, div});
        wb_read(REG_CLK_DIV, rd);
        check("CLK_DIV", 48'(rd), 48'(div));
        // Let the divider settle on the new count
        repeat (3) sd_clk_edge(1'b1);
        t0 = $time;
        sd_clk_edge(1'b1);
        t1 = $time;
        check("sd_clk_o period", 48'(t1 - t0), 48'(2 * (div + 1) * 100));
        report_test("interrupt mask, clear and clock divisor", start);
    endtask

    initial begin
        wb_clk    = 1'b0;
        err_cnt   = 0;
        chk_cnt   = 0;
        test_cnt  = 0;
        rst_n     <= 1'b0;
        wb_req    <= '0;
        sd_cmd_in <= 1'b1;
        repeat (4) @(posedge wb_clk);
        rst_n <= 1'b1;
        test_reset();
        test_no_response();
        test_good_response();
        test_bad_response();
        test_missing_response();
        test_irq_and_clock();
        $display("%0d tests, %0d checks, %0d errors", test_cnt, chk_cnt, err_cnt);
        if (err_cnt == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

// File: all.f
design/sd_host_pkg.sv
design/sd_clock_divider.sv
design/sd_cmd_serial.sv
design/sd_cmd_master.sv
design/sd_host_regs.sv
design/sd_host_top.sv
tb/sd_host_checker.sv
tb/sd_host_tb.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = sd_host_tb
FILELIST  = all.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)

.PHONY: all run lint clean

all: run

$(SIM): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM)
	@out=$$(./$(SIM) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -qx '>>> PASS'

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
